// ==== tb/tcb_mon_stim.txt ====
# rep(dec) bus_rst mode clr vld rdy wen adr siz byt wdt rsp_rdt rsp_err, then expected
# vio vio_seen vio_cnt trc_vld trc_adr trc_wen trc_rdt trc_err after the row's last cycle
# bus reset, release, second cycle after release
1 1 0 0 0 0 0 0000 0 0 00000000 00000000 0   00 00 00 0 0000 0 00000000 0
1 1 0 0 1 0 0 0010 2 0 00000000 00000000 0   01 01 01 0 0000 0 00000000 0
1 0 0 0 1 1 0 0010 2 0 00000000 00000000 0   02 03 02 0 0000 0 00000000 0
1 0 0 0 1 1 0 0020 2 0 00000000 11223344 0   00 03 02 1 0010 0 11223344 0
1 0 0 0 0 1 0 0000 0 0 00000000 aabbccdd 1   00 03 02 1 0020 0 aabbccdd 1
1 0 0 0 0 0 0 0000 0 0 00000000 00000000 0   00 03 02 0 0020 0 aabbccdd 1
# mode 0 size range and masked reads
1 0 0 0 1 1 1 0100 3 0 12345678 00000000 0   04 07 03 0 0020 0 aabbccdd 1
1 0 0 0 1 1 0 0104 2 0 00000000 deadbeef 0   00 07 03 1 0100 1 00000000 0
1 0 0 0 1 1 0 0108 0 0 00000000 cafef00d 0   00 07 03 1 0104 0 cafef00d 0
1 0 0 0 1 1 0 010a 1 0 00000000 99887766 0   00 07 03 1 0108 0 00000066 0
1 0 0 0 0 1 0 0000 0 0 00000000 55443322 1   00 07 03 1 010a 0 00003322 1
1 0 0 0 0 0 0 0000 0 0 00000000 00000000 0   00 07 03 0 010a 0 00003322 1
# mode 1 legal byte enables, back to back reads
1 0 1 0 1 1 0 0200 0 1 00000000 00000000 0   00 07 03 0 010a 0 00003322 1
1 0 1 0 1 1 0 0201 0 2 00000000 a1b2c3d4 0   00 07 03 1 0200 0 000000d4 0
1 0 1 0 1 1 0 0202 0 4 00000000 a1b2c3d4 0   00 07 03 1 0201 0 0000c300 0
1 0 1 0 1 1 0 0203 0 8 00000000 a1b2c3d4 0   00 07 03 1 0202 0 00b20000 0
1 0 1 0 1 1 0 0204 0 3 00000000 a1b2c3d4 0   00 07 03 1 0203 0 a1000000 0
1 0 1 0 1 1 0 0206 0 c 00000000 a1b2c3d4 0   00 07 03 1 0204 0 0000c3d4 0
1 0 1 0 1 1 0 0208 0 f 00000000 a1b2c3d4 0   00 07 03 1 0206 0 a1b20000 0
1 0 1 0 0 1 0 0000 0 0 00000000 a1b2c3d4 0   00 07 03 1 0208 0 a1b2c3d4 0
# mode 1 illegal byte enables on writes
1 0 1 0 1 1 1 0300 0 6 00000000 00000000 0   08 0f 04 0 0208 0 a1b2c3d4 0
1 0 1 0 1 1 1 0304 0 5 00000000 00000000 0   08 0f 05 1 0300 1 00000000 0
1 0 1 0 1 1 1 0308 0 0 00000000 00000000 0   08 0f 06 1 0304 1 00000000 0
1 0 1 0 0 1 0 0000 0 0 00000000 00000000 0   00 0f 06 1 0308 1 00000000 0
# stable stall, then a stall followed by a moved address
1 0 0 0 1 0 1 0400 2 0 0badf00d 00000000 0   00 0f 06 0 0308 1 00000000 0
1 0 0 0 1 0 1 0400 2 0 0badf00d 00000000 0   00 0f 06 0 0308 1 00000000 0
1 0 0 0 1 0 1 0400 2 0 0badf00d 00000000 0   00 0f 06 0 0308 1 00000000 0
1 0 0 0 1 1 1 0400 2 0 0badf00d 00000000 0   00 0f 06 0 0308 1 00000000 0
1 0 0 0 1 0 0 0500 2 0 00000000 00000000 0   00 0f 06 1 0400 1 00000000 0
1 0 0 0 1 1 0 0504 2 0 00000000 00000000 0   10 1f 07 0 0400 1 00000000 0
1 0 0 0 0 1 0 0000 0 0 00000000 76543210 0   00 1f 07 1 0504 0 76543210 0
# clear, clear against a violation, saturation
1 0 0 1 0 0 0 0000 0 0 00000000 00000000 0   00 00 00 0 0504 0 76543210 0
1 0 0 1 1 1 1 0600 3 0 00000000 00000000 0   04 04 01 0 0504 0 76543210 0
260 1 0 0 1 0 0 0700 2 0 00000000 00000000 0 01 05 ff 0 0600 1 00000000 0
1 0 0 0 0 0 0 0000 0 0 00000000 00000000 0   00 05 ff 0 0600 1 00000000 0
1 0 0 1 0 0 0 0000 0 0 00000000 00000000 0   00 00 00 0 0600 1 00000000 0
1 0 0 0 0 0 0 0000 0 0 00000000 00000000 0   00 00 00 0 0600 1 00000000 0

// ==== tcb_mon_top.f ====
common/tcb_mon_pkg.sv
hw/tcb_mon_ctrl.sv
hw/check/tcb_mon_req_check.sv
hw/rsp/tcb_mon_delay.sv
hw/rsp/tcb_mon_rsp_trace.sv
hw/tcb_mon_stats.sv
hw/tcb_mon_top.sv
tb/tcb_mon_tb.sv

// ==== Makefile ====
# Verilator build and run for the TCB-lite monitor testbench
# run from the project root, the testbench reads tb/tcb_mon_stim.txt

VERILATOR ?= verilator
TOP       ?= tcb_mon_tb
FLIST     ?= tcb_mon_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Verification passed

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# status follows the search for the pass line
run: compile
	@out="$$(./$(SIM) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/tcb_mon_tb.sv ====
/*
  drives tcb_mon_top with one stim row per cycle
  a row may repeat for several cycles
  expected columns hold after the edge that samples the last repetition
*/

`timescale 1ns/1ps

module tcb_mon_tb;

    // dut inputs
    logic                          mon;
    logic                          rst_n;
    logic                          bus_rst;
    logic                          vld;
    logic                          rdy;
    logic                          wen;
    logic [tcb_mon_pkg::ADR_W-1:0] adr;
    logic [tcb_mon_pkg::SIZ_W-1:0] siz;
    logic [tcb_mon_pkg::BYT_N-1:0] byt;
    logic [tcb_mon_pkg::DAT_W-1:0] wdt;
    logic [tcb_mon_pkg::DAT_W-1:0] rsp_rdt;
    logic                          rsp_err;
    logic                          mode;
    logic                          clr;
    // dut outputs
    logic [tcb_mon_pkg::VIO_W-1:0] vio;
    logic [tcb_mon_pkg::VIO_W-1:0] vio_seen;
    logic [tcb_mon_pkg::CNT_W-1:0] vio_cnt;
    logic                          trc_vld;
    logic [tcb_mon_pkg::ADR_W-1:0] trc_adr;
    logic                          trc_wen;
    logic [tcb_mon_pkg::DAT_W-1:0] trc_rdt;
    logic                          trc_err;

    // one stim file row with inputs then expected outputs
    typedef struct packed {
        logic [15:0]                   rep;
        logic                          bus_rst;
        logic                          mode;
        logic                          clr;
        logic                          vld;
        logic                          rdy;
        logic                          wen;
        logic [tcb_mon_pkg::ADR_W-1:0] adr;
        logic [tcb_mon_pkg::SIZ_W-1:0] siz;
        logic [tcb_mon_pkg::BYT_N-1:0] byt;
        logic [tcb_mon_pkg::DAT_W-1:0] wdt;
        logic [tcb_mon_pkg::DAT_W-1:0] rsp_rdt;
        logic                          rsp_err;
        logic [tcb_mon_pkg::VIO_W-1:0] vio;
        logic [tcb_mon_pkg::VIO_W-1:0] vio_seen;
        logic [tcb_mon_pkg::CNT_W-1:0] vio_cnt;
        logic                          trc_vld;
        logic [tcb_mon_pkg::ADR_W-1:0] trc_adr;
        logic                          trc_wen;
        logic [tcb_mon_pkg::DAT_W-1:0] trc_rdt;
        logic                          trc_err;
    } row_t;

    row_t        rows [$];
    // clock cycles the stimulus takes
    // stays zero until the file is read
    int unsigned run_cycles;

    tcb_mon_top i_tcb_mon_top (
        .mon      (mon),
        .rst_n    (rst_n),
        .bus_rst  (bus_rst),
        .vld      (vld),
        .rdy      (rdy),
        .wen      (wen),
        .adr      (adr),
        .siz      (siz),
        .byt      (byt),
        .wdt      (wdt),
        .rsp_rdt  (rsp_rdt),
        .rsp_err  (rsp_err),
        .mode     (mode),
        .clr      (clr),
        .vio      (vio),
        .vio_seen (vio_seen),
        .vio_cnt  (vio_cnt),
        .trc_vld  (trc_vld),
        .trc_adr  (trc_adr),
        .trc_wen  (trc_wen),
        .trc_rdt  (trc_rdt),
        .trc_err  (trc_err)
    );

    // 40 ns period
    always #20 mon = ~mon;

    ////////////////////
    // stim file
    ////////////////////

    task automatic load_stim();
        string       line;
        int          fd;
        int          code;
        int          n_col;
        int unsigned total;
        logic [31:0] col [21];
        row_t        r;
        total = 0;
        fd = $fopen("tb/tcb_mon_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open tb/tcb_mon_stim.txt");
            $display("Verification failed");
            $fatal(1, "missing stimulus file");
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            // skip blank and comment lines
            if (code > 1 && line.getc(0) != "#") begin
                n_col = $sscanf(line,
                                "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                col[0], col[1], col[2], col[3], col[4], col[5], col[6],
                                col[7], col[8], col[9], col[10], col[11], col[12], col[13],
                                col[14], col[15], col[16], col[17], col[18], col[19], col[20]);
                if (n_col != 21 || col[0] == 0) begin
                    $display("stim row %0d is malformed: %s", rows.size(), line);
                    $display("Verification failed");
                    $fatal(1, "bad stimulus row");
                end
                r.rep      = col[0][15:0];
                r.bus_rst  = col[1][0];
                r.mode     = col[2][0];
                r.clr      = col[3][0];
                r.vld      = col[4][0];
                r.rdy      = col[5][0];
                r.wen      = col[6][0];
                r.adr      = col[7][tcb_mon_pkg::ADR_W-1:0];
                r.siz      = col[8][tcb_mon_pkg::SIZ_W-1:0];
                r.byt      = col[9][tcb_mon_pkg::BYT_N-1:0];
                r.wdt      = col[10];
                r.rsp_rdt  = col[11];
                r.rsp_err  = col[12][0];
                r.vio      = col[13][tcb_mon_pkg::VIO_W-1:0];
                r.vio_seen = col[14][tcb_mon_pkg::VIO_W-1:0];
                r.vio_cnt  = col[15][tcb_mon_pkg::CNT_W-1:0];
                r.trc_vld  = col[16][0];
                r.trc_adr  = col[17][tcb_mon_pkg::ADR_W-1:0];
                r.trc_wen  = col[18][0];
                r.trc_rdt  = col[19];
                r.trc_err  = col[20][0];
                rows.push_back(r);
                total += col[0];
            end
        end
        $fclose(fd);
        if (rows.size() == 0) begin
            $display("stim file holds no rows");
            $display("Verification failed");
            $fatal(1, "empty stimulus");
        end
        run_cycles = total;
    endtask

    ////////////////////
    // drive and compare
    ////////////////////

    // called right after a rising edge so the dut sees the row at the next one
    task automatic apply_row(input row_t r);
        bus_rst <= r.bus_rst;
        mode    <= r.mode;
        clr     <= r.clr;
        vld     <= r.vld;
        rdy     <= r.rdy;
        wen     <= r.wen;
        adr     <= r.adr;
        siz     <= r.siz;
        byt     <= r.byt;
        wdt     <= r.wdt;
        rsp_rdt <= r.rsp_rdt;
        rsp_err <= r.rsp_err;
    endtask

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp, input int idx);
        assert (got === exp) else begin
            $display("Error: %0t ns, row %0d, %s = %h, expected %h", $time, idx, name, got, exp);
            $display("Verification failed");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic compare_row(input row_t r, input int idx);
        compare_field("vio", 32'(vio), 32'(r.vio), idx);
        compare_field("vio_seen", 32'(vio_seen), 32'(r.vio_seen), idx);
        compare_field("vio_cnt", 32'(vio_cnt), 32'(r.vio_cnt), idx);
        compare_field("trc_vld", 32'(trc_vld), 32'(r.trc_vld), idx);
        compare_field("trc_adr", 32'(trc_adr), 32'(r.trc_adr), idx);
        compare_field("trc_wen", 32'(trc_wen), 32'(r.trc_wen), idx);
        compare_field("trc_rdt", trc_rdt, r.trc_rdt, idx);
        compare_field("trc_err", 32'(trc_err), 32'(r.trc_err), idx);
    endtask

    initial begin
        mon        = 1'b0;
        rst_n      = 1'b0;
        bus_rst    = 1'b1;
        vld        = 1'b0;
        rdy        = 1'b0;
        wen        = 1'b0;
        adr        = '0;
        siz        = '0;
        byt        = '0;
        wdt        = '0;
        rsp_rdt    = '0;
        rsp_err    = 1'b0;
        mode       = 1'b0;
        clr        = 1'b0;
        run_cycles = 0;
        load_stim();
        repeat (3) @(posedge mon);
        rst_n <= 1'b1;
        for (int i = 0; i < rows.size(); i++) begin
            @(posedge mon);
            apply_row(rows[i]);
            // outputs of the row before are settled at the falling edge
            if (i > 0) begin
                @(negedge mon);
                compare_row(rows[i-1], i - 1);
            end
            repeat (rows[i].rep - 1) @(posedge mon);
        end
        @(posedge mon);
        @(negedge mon);
        compare_row(rows[rows.size()-1], rows.size() - 1);
        $display("Verification passed");
        $finish;
    end

    // watchdog covers the stimulus length plus reset and some slack
    initial begin
        wait (run_cycles != 0);
        #((run_cycles + 3 + 20) * 40);
        $display("timeout, the stimulus did not finish within %0d cycles", run_cycles + 23);
        $display("Verification failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== hw/tcb_mon_top.sv ====
/*
  passive TCB-lite monitor, every bus signal is an input
  mode may change between tests but must be stable while transfers are in flight
*/

`timescale 1ns/1ps

module tcb_mon_top (
    input  logic                          mon,
    input  logic                          rst_n,
    // observed bus
    input  logic                          bus_rst,
    input  logic                          vld,
    input  logic                          rdy,
    input  logic                          wen,
    input  logic [tcb_mon_pkg::ADR_W-1:0] adr,
    input  logic [tcb_mon_pkg::SIZ_W-1:0] siz,
    input  logic [tcb_mon_pkg::BYT_N-1:0] byt,
    input  logic [tcb_mon_pkg::DAT_W-1:0] wdt,
    input  logic [tcb_mon_pkg::DAT_W-1:0] rsp_rdt,
    input  logic                          rsp_err,
    // strap and clear
    input  logic                          mode,
    input  logic                          clr,
    // violation report
    output logic [tcb_mon_pkg::VIO_W-1:0] vio,
    output logic [tcb_mon_pkg::VIO_W-1:0] vio_seen,
    output logic [tcb_mon_pkg::CNT_W-1:0] vio_cnt,
    // trace record
    output logic                          trc_vld,
    output logic [tcb_mon_pkg::ADR_W-1:0] trc_adr,
    output logic                          trc_wen,
    output logic [tcb_mon_pkg::DAT_W-1:0] trc_rdt,
    output logic                          trc_err
);

    ////////////////////
    // handshake
    ////////////////////

    logic xfer;
    logic stall_prev;
    logic vio_rst;
    logic vio_rel;

    tcb_mon_ctrl i_ctrl (
        .mon        (mon),
        .rst_n      (rst_n),
        .bus_rst    (bus_rst),
        .vld        (vld),
        .rdy        (rdy),
        .xfer       (xfer),
        .stall_prev (stall_prev),
        .vio_rst    (vio_rst),
        .vio_rel    (vio_rel)
    );

    ////////////////////
    // request rules
    ////////////////////

    logic vio_siz;
    logic vio_byt;
    logic vio_stl;

    tcb_mon_req_check i_req_check (
        .mon        (mon),
        .rst_n      (rst_n),
        .vld        (vld),
        .mode       (mode),
        .stall_prev (stall_prev),
        .wen        (wen),
        .adr        (adr),
        .siz        (siz),
        .byt        (byt),
        .wdt        (wdt),
        .vio_siz    (vio_siz),
        .vio_byt    (vio_byt),
        .vio_stl    (vio_stl)
    );

    // summary and counter
    tcb_mon_stats i_stats (
        .mon      (mon),
        .rst_n    (rst_n),
        .clr      (clr),
        .vio_rst  (vio_rst),
        .vio_rel  (vio_rel),
        .vio_siz  (vio_siz),
        .vio_byt  (vio_byt),
        .vio_stl  (vio_stl),
        .vio      (vio),
        .vio_seen (vio_seen),
        .vio_cnt  (vio_cnt)
    );

    ////////////////////
    // response path
    ////////////////////

    // request fields the response side needs
    tcb_mon_pkg::req_rec_t rec;
    tcb_mon_pkg::req_rec_t rec_dly;
    logic                  xfer_dly;

    always_comb begin
        rec.wen  = wen;
        rec.mode = mode;
        rec.siz  = siz;
        rec.byt  = byt;
        rec.adr  = adr;
    end

    // record and flag travel in step
    tcb_mon_delay #(.payload_t(tcb_mon_pkg::req_rec_t)) i_rec_dly (
        .mon   (mon),
        .rst_n (rst_n),
        .din   (rec),
        .dout  (rec_dly)
    );

    tcb_mon_delay #(.payload_t(logic)) i_xfer_dly (
        .mon   (mon),
        .rst_n (rst_n),
        .din   (xfer),
        .dout  (xfer_dly)
    );

    tcb_mon_rsp_trace i_rsp_trace (
        .mon      (mon),
        .rst_n    (rst_n),
        .xfer_dly (xfer_dly),
        .rec_dly  (rec_dly),
        .rsp_rdt  (rsp_rdt),
        .rsp_err  (rsp_err),
        .trc_vld  (trc_vld),
        .trc_adr  (trc_adr),
        .trc_wen  (trc_wen),
        .trc_rdt  (trc_rdt),
        .trc_err  (trc_err)
    );

endmodule

// ==== hw/tcb_mon_stats.sv ====
/*
  vio shows the violations of the previous edge for one cycle
  a violation in the same cycle as clr survives the clear
*/

`timescale 1ns/1ps

module tcb_mon_stats (
    input  logic                          mon,
    input  logic                          rst_n,
    // clears summary and count
    input  logic                          clr,
    // violation pulses from ctrl and checker
    input  logic                          vio_rst,
    input  logic                          vio_rel,
    input  logic                          vio_siz,
    input  logic                          vio_byt,
    input  logic                          vio_stl,
    // registered outputs
    output logic [tcb_mon_pkg::VIO_W-1:0] vio,
    output logic [tcb_mon_pkg::VIO_W-1:0] vio_seen,
    output logic [tcb_mon_pkg::CNT_W-1:0] vio_cnt
);

    // merged vector for this edge
    logic [tcb_mon_pkg::VIO_W-1:0] vio_nxt;

    always_comb begin
        vio_nxt                       = '0;
        vio_nxt[tcb_mon_pkg::VIO_RST] = vio_rst;
        vio_nxt[tcb_mon_pkg::VIO_REL] = vio_rel;
        vio_nxt[tcb_mon_pkg::VIO_SIZ] = vio_siz;
        vio_nxt[tcb_mon_pkg::VIO_BYT] = vio_byt;
        vio_nxt[tcb_mon_pkg::VIO_STL] = vio_stl;
    end

    // summary and count after an optional clear
    logic [tcb_mon_pkg::VIO_W-1:0] seen_base;
    logic [tcb_mon_pkg::CNT_W-1:0] cnt_base;

    assign seen_base = clr ? '0 : vio_seen;
    assign cnt_base  = clr ? '0 : vio_cnt;

    always_ff @(posedge mon or negedge rst_n) begin
        if (!rst_n) begin
            vio      <= '0;
            vio_seen <= '0;
            vio_cnt  <= '0;
        end else begin
            vio      <= vio_nxt;
            vio_seen <= seen_base | vio_nxt;
            // one count per violating cycle, stuck at all ones
            if ((|vio_nxt) && (cnt_base != '1)) begin
                vio_cnt <= cnt_base + 1'b1;
            end else begin
                vio_cnt <= cnt_base;
            end
        end
    end

endmodule

// ==== hw/rsp/tcb_mon_rsp_trace.sv ====
/*
  response is sampled on the edge where the delayed transfer flag is high
  read lanes outside the request read as zero, writes report zero data
*/

`timescale 1ns/1ps

module tcb_mon_rsp_trace (
    input  logic                          mon,
    input  logic                          rst_n,
    // request side, delayed by RSP_DLY
    input  logic                          xfer_dly,
    input  tcb_mon_pkg::req_rec_t         rec_dly,
    // response from the subordinate
    input  logic [tcb_mon_pkg::DAT_W-1:0] rsp_rdt,
    input  logic                          rsp_err,
    // trace record
    output logic                          trc_vld,
    output logic [tcb_mon_pkg::ADR_W-1:0] trc_adr,
    output logic                          trc_wen,
    output logic [tcb_mon_pkg::DAT_W-1:0] trc_rdt,
    output logic                          trc_err
);

    ////////////////////
    // lane mask
    ////////////////////

    // lanes the request asked for
    logic [tcb_mon_pkg::BYT_N-1:0] lane;
    // read data with unused lanes zeroed
    logic [tcb_mon_pkg::DAT_W-1:0] rdt_msk;

    always_comb begin
        for (int unsigned i = 0; i < tcb_mon_pkg::BYT_N; i++) begin
            // mode 0 keeps lanes 0 .. 2**siz-1, mode 1 follows byt
            if (rec_dly.mode) begin
                lane[i] = rec_dly.byt[i];
            end else begin
                lane[i] = (i < (1 << rec_dly.siz));
            end
            // writes carry no read data
            rdt_msk[8*i+:8] = (lane[i] & ~rec_dly.wen) ? rsp_rdt[8*i+:8] : 8'h00;
        end
    end

    ////////////////////
    // record
    ////////////////////

    always_ff @(posedge mon or negedge rst_n) begin
        if (!rst_n) begin
            trc_vld <= 1'b0;
            trc_adr <= '0;
            trc_wen <= 1'b0;
            trc_rdt <= '0;
            trc_err <= 1'b0;
        end else begin
            // one cycle pulse per completed transfer
            trc_vld <= xfer_dly;
            // fields hold until the next record
            if (xfer_dly) begin
                trc_adr <= rec_dly.adr;
                trc_wen <= rec_dly.wen;
                trc_rdt <= rdt_msk;
                trc_err <= rsp_err;
            end
        end
    end

endmodule

// ==== hw/rsp/tcb_mon_delay.sv ====
/*
  fixed delay of RSP_DLY cycles, all stages reset to zero
  payload_t must be a packed type
*/

`timescale 1ns/1ps

module tcb_mon_delay #(
    parameter type payload_t = logic
) (
    input  logic     mon,
    input  logic     rst_n,
    input  payload_t din,
    output payload_t dout
);

    // stage 0 takes din, last stage is the output
    payload_t stg [tcb_mon_pkg::RSP_DLY];

    always_ff @(posedge mon or negedge rst_n) begin
        if (!rst_n) begin
            for (int unsigned i = 0; i < tcb_mon_pkg::RSP_DLY; i++) begin
                stg[i] <= '0;
            end
        end else begin
            stg[0] <= din;
            // shift towards the output
            for (int unsigned i = 1; i < tcb_mon_pkg::RSP_DLY; i++) begin
                stg[i] <= stg[i-1];
            end
        end
    end

    assign dout = stg[tcb_mon_pkg::RSP_DLY-1];

endmodule

// ==== hw/check/tcb_mon_req_check.sv ====
/*
  request rules per edge with combinational outputs
  byte enable legality assumes 4 lanes
  stall check also covers wdt on reads
*/

`timescale 1ns/1ps

module tcb_mon_req_check (
    input  logic                           mon,
    input  logic                           rst_n,
    input  logic                           vld,
    // low for log size, high for byte enables
    input  logic                           mode,
    // previous cycle was a stall
    input  logic                           stall_prev,
    // request payload
    input  logic                           wen,
    input  logic [tcb_mon_pkg::ADR_W-1:0]  adr,
    input  logic [tcb_mon_pkg::SIZ_W-1:0]  siz,
    input  logic [tcb_mon_pkg::BYT_N-1:0]  byt,
    input  logic [tcb_mon_pkg::DAT_W-1:0]  wdt,
    // violations at this edge
    output logic                           vio_siz,
    output logic                           vio_byt,
    output logic                           vio_stl
);

    ////////////////////
    // format rules
    ////////////////////

    // set when byt is one of the aligned lane groups
    logic byt_legal;

    always_comb begin
        case (byt)
            // single bytes
            4'b0001, 4'b0010, 4'b0100, 4'b1000: byt_legal = 1'b1;
            // aligned half words
            4'b0011, 4'b1100:                   byt_legal = 1'b1;
            // full word
            4'b1111:                            byt_legal = 1'b1;
            default:                            byt_legal = 1'b0;
        endcase
    end

    // size field only meaningful in mode 0
    assign vio_siz = vld & ~mode & (siz > tcb_mon_pkg::SIZ_W'(tcb_mon_pkg::MAX_SIZ));

    // byte enables only meaningful in mode 1
    assign vio_byt = vld & mode & ~byt_legal;

    ////////////////////
    // stall stability
    ////////////////////

    // copy of the last request seen with valid high
    logic                          cpy_wen;
    logic [tcb_mon_pkg::ADR_W-1:0] cpy_adr;
    logic [tcb_mon_pkg::SIZ_W-1:0] cpy_siz;
    logic [tcb_mon_pkg::BYT_N-1:0] cpy_byt;
    logic [tcb_mon_pkg::DAT_W-1:0] cpy_wdt;

    always_ff @(posedge mon or negedge rst_n) begin
        if (!rst_n) begin
            cpy_wen <= 1'b0;
            cpy_adr <= '0;
            cpy_siz <= '0;
            cpy_byt <= '0;
            cpy_wdt <= '0;
        end else if (vld) begin
            cpy_wen <= wen;
            cpy_adr <= adr;
            cpy_siz <= siz;
            cpy_byt <= byt;
            cpy_wdt <= wdt;
        end
    end

    // any field moved since the stalled cycle
    logic req_diff;

    assign req_diff = (wen != cpy_wen) | (adr != cpy_adr) | (siz != cpy_siz)
                    | (byt != cpy_byt) | (wdt != cpy_wdt);

    // a stalled request must come back unchanged
    assign vio_stl = vld & stall_prev & req_diff;

endmodule

// ==== hw/tcb_mon_ctrl.sv ====
/*
  bus_rst is the observed bus's synchronous reset, sampled on mon
  violation flags are combinational, registering happens in the stats block
*/

`timescale 1ns/1ps

module tcb_mon_ctrl (
    input  logic mon,
    input  logic rst_n,
    // observed bus handshake
    input  logic bus_rst,
    input  logic vld,
    input  logic rdy,
    // decoded state
    output logic xfer,
    output logic stall_prev,
    // handshake layer violations
    output logic vio_rst,
    output logic vio_rel
);

    ////////////////////
    // history
    ////////////////////

    // bus reset level of the previous cycle
    logic bus_rst_prev;

    // current cycle is a stall
    logic stall;

    assign stall = vld & ~rdy;

    always_ff @(posedge mon or negedge rst_n) begin
        if (!rst_n) begin
            bus_rst_prev <= 1'b0;
            stall_prev   <= 1'b0;
        end else begin
            bus_rst_prev <= bus_rst;
            // checker compares against the copy taken in this cycle
            stall_prev   <= stall;
        end
    end

    ////////////////////
    // decode
    ////////////////////

    // handshake completes on this edge
    assign xfer = vld & rdy;

    // valid must stay low while the bus is held in reset
    assign vio_rst = vld & bus_rst;

    // first cycle after release, reset fell on the previous edge
    assign vio_rel = vld & bus_rst_prev & ~bus_rst;

endmodule

// ==== common/tcb_mon_pkg.sv ====
/*
  shared widths and encodings for the TCB-lite monitor, 4 byte lanes only
  violation bit positions index the vio vector of tcb_mon_top
*/

package tcb_mon_pkg;

    ////////////////////
    // bus geometry
    ////////////////////

    // data bus width in bits
    localparam int unsigned DAT_W = 32;
    // byte lanes on the data bus
    localparam int unsigned BYT_N = DAT_W / 8;
    // address width
    localparam int unsigned ADR_W = 16;
    // logarithmic size field width (mode 0)
    localparam int unsigned SIZ_W = 2;
    // largest legal log2 size, 4 bytes
    localparam int unsigned MAX_SIZ = 2;

    // read response arrives this many cycles after the transfer edge
    localparam int unsigned RSP_DLY = 1;

    ////////////////////
    // violations
    ////////////////////

    localparam int unsigned VIO_W = 5;
    // valid while the bus is in reset
    localparam int unsigned VIO_RST = 0;
    // valid in the first cycle after bus reset release
    localparam int unsigned VIO_REL = 1;
    // size field beyond MAX_SIZ
    localparam int unsigned VIO_SIZ = 2;
    // byte enable pattern not in the legal set
    localparam int unsigned VIO_BYT = 3;
    // request changed while stalled
    localparam int unsigned VIO_STL = 4;

    // saturating violation counter
    localparam int unsigned CNT_W = 8;

    ////////////////////
    // request record
    ////////////////////

    // what the response side needs to know about an accepted transfer
    typedef struct packed {
        logic             wen;   // 1 = write
        logic             mode;  // format at request time
        logic [SIZ_W-1:0] siz;   // log2 size, mode 0
        logic [BYT_N-1:0] byt;   // byte enables, mode 1
        logic [ADR_W-1:0] adr;
    } req_rec_t;

endpackage
